//--- hw/zx_pkg.sv
`default_nettype none

package zx_pkg;

	// cpu bus as seen by the core, strobes active high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        mreq;
		logic        iorq;
		logic        rd;
		logic        wr;
		logic        m1;
	} cpu_bus_t;

	typedef enum logic [1:0] {
		MODE_128,
		MODE_48,
		MODE_PLUS3
	} mem_mode_e;

	// cpu_freq 0..4 selects 3.5 to 56 MHz
	typedef struct packed {
		mem_mode_e  mem_mode;
		logic [2:0] cpu_freq;
		logic       pause;
	} core_cfg_t;

	typedef enum logic [3:0] {
		PORT_NONE,
		PORT_7FFD,
		PORT_1FFD,
		PORT_FE,
		PORT_COVOX,
		PORT_SD_A,
		PORT_SD_B,
		PORT_SD_C,
		PORT_SD_D
	} port_e;

	// single cycle port write
	typedef struct packed {
		port_e      port;
		logic [7:0] data;
	} io_wr_t;

	typedef logic [21:0] mem_addr_t;

	typedef struct packed {
		mem_addr_t addr;
		logic      writable;
	} mem_map_t;

	typedef struct packed {
		mem_addr_t  addr;
		logic       we;
		logic [7:0] data;
	} mem_req_t;

	// memory layout
	localparam int PAGE_BITS = 14;
	localparam mem_addr_t ROM_BASE = 22'h200000;
	localparam logic [3:0] ROM_BANK_48 = 4'd15;
	localparam logic [3:0] ROM_BANK_128 = 4'd6;
	localparam logic [3:0] ROM_BANK_PLUS3 = 4'd8;

	// low address bytes of the dac ports
	localparam logic [7:0] COVOX_PORT = 8'hfb;
	localparam logic [7:0] SD_PORT_A = 8'h0f;
	localparam logic [7:0] SD_PORT_B = 8'h1f;
	localparam logic [7:0] SD_PORT_C = 8'h4f;
	localparam logic [7:0] SD_PORT_D = 8'h5f;

	// cpu enable period is mask + 1 cycles
	typedef logic [4:0] turbo_mask_t;
	localparam logic [2:0] FREQ_CODE_MAX = 3'd4;
	localparam turbo_mask_t TURBO_MASKS [0:4] = '{
		5'b11111, 5'b01111, 5'b00111, 5'b00011, 5'b00001
	};

	localparam int SAMPLE_W = 16;

endpackage

`default_nettype wire

//--- hw/sigma_delta_dac.sv
`timescale 1ns/1ps
`default_nettype none

module sigma_delta_dac import zx_pkg::*; (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic [SAMPLE_W-1:0] din,
	output logic                dout
);
	// one extra bit holds the carry
	logic [SAMPLE_W:0] acc;

	always_ff @(posedge clk_sys) begin
		if (reset)
			acc <= '0;
		else
			acc <= {1'b0, acc[SAMPLE_W-1:0]} + {1'b0, din};
	end

	// carry rate follows din / 2^16
	assign dout = acc[SAMPLE_W];

endmodule

`default_nettype wire

//--- hw/audio_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module audio_mixer import zx_pkg::*; (
	input  logic                clk_sys,
	input  logic                reset,
	input  io_wr_t              io_wr,
	output logic [SAMPLE_W-1:0] sample_left,
	output logic [SAMPLE_W-1:0] sample_right
);
	logic [7:0] dac_l0;
	logic [7:0] dac_l1;
	logic [7:0] dac_r0;
	logic [7:0] dac_r1;
	logic       ear;
	logic       mic;

	// two dac bytes at x32, ear at x8192, mic at x4096
	function automatic logic [SAMPLE_W-1:0] mix(input logic [7:0] a, input logic [7:0] b,
		input logic e, input logic m);
		mix = SAMPLE_W'({a, 5'd0}) + SAMPLE_W'({b, 5'd0}) + SAMPLE_W'({e, m, 12'd0});
	endfunction

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dac_l0 <= '0;
			dac_l1 <= '0;
			dac_r0 <= '0;
			dac_r1 <= '0;
			ear <= 1'b0;
			mic <= 1'b0;
		end else begin
			// covox drives all four channels at once
			if (io_wr.port == PORT_COVOX || io_wr.port == PORT_SD_A)
				dac_l0 <= io_wr.data;
			if (io_wr.port == PORT_COVOX || io_wr.port == PORT_SD_B)
				dac_l1 <= io_wr.data;
			if (io_wr.port == PORT_COVOX || io_wr.port == PORT_SD_C)
				dac_r0 <= io_wr.data;
			if (io_wr.port == PORT_COVOX || io_wr.port == PORT_SD_D)
				dac_r1 <= io_wr.data;
			if (io_wr.port == PORT_FE) begin
				ear <= io_wr.data[4];
				mic <= io_wr.data[3];
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sample_left <= '0;
			sample_right <= '0;
		end else begin
			sample_left <= mix(dac_l0, dac_l1, ear, mic);
			sample_right <= mix(dac_r0, dac_r1, ear, mic);
		end
	end

endmodule

`default_nettype wire

//--- hw/page_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module page_mapper import zx_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [15:0] bus_addr,
	input  mem_mode_e   mem_mode,
	input  io_wr_t      io_wr,
	output mem_map_t    mem_map
);
	logic [7:0]           reg_7ffd;
	logic [7:0]           reg_1ffd;
	mem_mode_e            mode;
	logic                 locked;
	logic                 special;
	logic [1:0]           quarter;
	logic [PAGE_BITS-1:0] offset;
	logic [3:0]           rom_bank;
	logic [2:0]           ram_page;
	logic [3:0][2:0]      special_pages;
	logic                 rom_sel;

	// 48 mode never pages
	assign locked = (mode == MODE_48) | reg_7ffd[5];
	assign special = (mode == MODE_PLUS3) & reg_1ffd[0];
	assign quarter = bus_addr[15:PAGE_BITS];
	assign offset = bus_addr[PAGE_BITS-1:0];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			reg_7ffd <= '0;
			reg_1ffd <= '0;
			mode <= mem_mode;
		end else if (!locked) begin
			if (io_wr.port == PORT_7FFD)
				reg_7ffd <= io_wr.data;
			if (io_wr.port == PORT_1FFD && mode == MODE_PLUS3)
				reg_1ffd <= io_wr.data;
		end
	end

	always_comb begin
		case (mode)
			MODE_48:    rom_bank = ROM_BANK_48;
			MODE_PLUS3: rom_bank = ROM_BANK_PLUS3 + {2'b00, reg_1ffd[2], reg_7ffd[4]};
			default:    rom_bank = ROM_BANK_128 + {3'b000, reg_7ffd[4]};
		endcase
	end

	// +3 all-ram layouts, quarter 3 first
	always_comb begin
		case (reg_1ffd[2:1])
			2'b00:   special_pages = {3'd3, 3'd2, 3'd1, 3'd0};
			2'b01:   special_pages = {3'd7, 3'd6, 3'd5, 3'd4};
			2'b10:   special_pages = {3'd3, 3'd6, 3'd5, 3'd4};
			default: special_pages = {3'd3, 3'd6, 3'd7, 3'd4};
		endcase
	end

	always_comb begin
		rom_sel = 1'b0;
		ram_page = 3'd0;
		if (special) begin
			ram_page = special_pages[quarter];
		end else begin
			case (quarter)
				2'd0:    rom_sel = 1'b1;
				2'd1:    ram_page = 3'd5;
				2'd2:    ram_page = 3'd2;
				default: ram_page = reg_7ffd[2:0];
			endcase
		end
	end

	assign mem_map.addr = rom_sel ? ROM_BASE + mem_addr_t'({rom_bank, offset})
		: mem_addr_t'({ram_page, offset});
	assign mem_map.writable = ~rom_sel;

	a_lock_holds: assert property (@(posedge clk_sys) disable iff (reset)
		locked |=> $stable(reg_7ffd));

endmodule

`default_nettype wire

//--- hw/cpu_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_clk_gen import zx_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic [2:0] cpu_freq,
	input  logic       pause,
	input  logic       mem_busy,
	output logic       ce_cpu_p,
	output logic       ce_cpu_n
);
	logic [4:0]  counter;
	logic [4:0]  masked;
	turbo_mask_t turbo;
	turbo_mask_t turbo_req;
	logic        p_point;
	logic        n_point;
	logic        cpu_en;
	logic [1:0]  switch_timeout;
	logic        stall_allowed;

	// out of range codes fall back to 3.5 MHz
	assign turbo_req = (cpu_freq > FREQ_CODE_MAX) ? TURBO_MASKS[0] : TURBO_MASKS[cpu_freq];
	assign masked = counter & turbo;
	// slow codes assume memory keeps up
	assign stall_allowed = ~|turbo[4:3];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			counter <= '0;
			p_point <= 1'b0;
			n_point <= 1'b0;
		end else begin
			counter <= counter + 5'd1;
			p_point <= masked == 5'd0;
			// n point sits at the top bit of the mask, half a period on
			n_point <= masked == (turbo ^ {1'b0, turbo[4:1]});
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			turbo <= turbo_req;
			cpu_en <= 1'b1;
			switch_timeout <= 2'd0;
		end else if (n_point) begin
			if (switch_timeout != 2'd0)
				switch_timeout <= switch_timeout + 2'd1;
			if (turbo != turbo_req) begin
				// hold the cpu across a speed change
				turbo <= turbo_req;
				cpu_en <= 1'b0;
				switch_timeout <= 2'd1;
			end else if (!cpu_en && switch_timeout == 2'd0 && !mem_busy) begin
				cpu_en <= ~pause;
			end else if (stall_allowed && mem_busy) begin
				cpu_en <= 1'b0;
			end else if (cpu_en && pause) begin
				cpu_en <= 1'b0;
			end
		end
	end

	assign ce_cpu_p = cpu_en & p_point;
	assign ce_cpu_n = cpu_en & n_point;

	a_ce_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(ce_cpu_p && ce_cpu_n));

endmodule

`default_nettype wire

//--- hw/bus_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module bus_ctrl import zx_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  cpu_bus_t  bus,
	input  mem_mode_e mem_mode,
	input  mem_map_t  mem_map,
	output io_wr_t    io_wr,
	output logic      mem_req_valid,
	output mem_req_t  mem_req,
	input  logic      mem_req_ready,
	output logic      mem_busy
);
	logic  io_wr_now;
	logic  io_wr_prev;
	logic  io_wr_edge;
	logic  mem_rd_now;
	logic  mem_wr_now;
	logic  mem_rd_prev;
	logic  mem_wr_prev;
	logic  req_start;
	logic  req_load;
	port_e port_sel;

	// i/o write outside of interrupt acknowledge
	assign io_wr_now = bus.iorq & bus.wr & ~bus.m1;
	assign io_wr_edge = io_wr_now & ~io_wr_prev;

	assign mem_rd_now = bus.mreq & bus.rd;
	assign mem_wr_now = bus.mreq & bus.wr;
	assign req_start = (mem_rd_now & ~mem_rd_prev) | (mem_wr_now & ~mem_wr_prev);
	// the slot is free, or the pending request hands off this cycle
	assign req_load = req_start & (~mem_req_valid | mem_req_ready);
	assign mem_busy = mem_req_valid | req_start;

	// first matching rule wins
	always_comb begin
		if (!bus.addr[15] && !bus.addr[1] && (bus.addr[14] || mem_mode != MODE_PLUS3))
			port_sel = PORT_7FFD;
		else if (mem_mode == MODE_PLUS3 && bus.addr[15:12] == 4'b0001 && !bus.addr[1])
			port_sel = PORT_1FFD;
		else if (!bus.addr[0])
			port_sel = PORT_FE;
		else if (bus.addr[7:0] == COVOX_PORT)
			port_sel = PORT_COVOX;
		else if (bus.addr[7:0] == SD_PORT_A)
			port_sel = PORT_SD_A;
		else if (bus.addr[7:0] == SD_PORT_B)
			port_sel = PORT_SD_B;
		else if (bus.addr[7:0] == SD_PORT_C)
			port_sel = PORT_SD_C;
		else if (bus.addr[7:0] == SD_PORT_D)
			port_sel = PORT_SD_D;
		else
			port_sel = PORT_NONE;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_prev <= 1'b0;
			mem_rd_prev <= 1'b0;
			mem_wr_prev <= 1'b0;
			io_wr.port <= PORT_NONE;
			io_wr.data <= '0;
			mem_req_valid <= 1'b0;
		end else begin
			io_wr_prev <= io_wr_now;
			mem_rd_prev <= mem_rd_now;
			mem_wr_prev <= mem_wr_now;
			io_wr.port <= io_wr_edge ? port_sel : PORT_NONE;
			io_wr.data <= bus.data;
			if (req_load)
				mem_req_valid <= 1'b1;
			else if (mem_req_ready)
				mem_req_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (req_load) begin
			mem_req.addr <= mem_map.addr;
			// writes to rom go out as reads
			mem_req.we <= mem_wr_now & mem_map.writable;
			mem_req.data <= bus.data;
		end
	end

	a_req_hold: assert property (@(posedge clk_sys) disable iff (reset)
		mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req));

	// cpu started a new access before memory took the last one
	a_req_overlap: assert property (@(posedge clk_sys) disable iff (reset)
		req_start |-> !mem_req_valid || mem_req_ready);

endmodule

`default_nettype wire

//--- hw/zx_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module zx_core_top import zx_pkg::*; (
	input  logic                clk_sys,
	input  logic                reset,
	input  cpu_bus_t            bus,
	input  core_cfg_t           cfg,
	output logic                mem_req_valid,
	output mem_req_t            mem_req,
	input  logic                mem_req_ready,
	output logic                ce_cpu_p,
	output logic                ce_cpu_n,
	output logic [SAMPLE_W-1:0] sample_left,
	output logic [SAMPLE_W-1:0] sample_right,
	output logic                audio_l,
	output logic                audio_r
);
	io_wr_t   io_wr;
	mem_map_t mem_map;
	logic     mem_busy;

	bus_ctrl bus_ctrl_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.bus           (bus),
		.mem_mode      (cfg.mem_mode),
		.mem_map       (mem_map),
		.io_wr         (io_wr),
		.mem_req_valid (mem_req_valid),
		.mem_req       (mem_req),
		.mem_req_ready (mem_req_ready),
		.mem_busy      (mem_busy)
	);

	cpu_clk_gen cpu_clk_gen_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cpu_freq (cfg.cpu_freq),
		.pause    (cfg.pause),
		.mem_busy (mem_busy),
		.ce_cpu_p (ce_cpu_p),
		.ce_cpu_n (ce_cpu_n)
	);

	page_mapper page_mapper_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.bus_addr (bus.addr),
		.mem_mode (cfg.mem_mode),
		.io_wr    (io_wr),
		.mem_map  (mem_map)
	);

	audio_mixer audio_mixer_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.io_wr        (io_wr),
		.sample_left  (sample_left),
		.sample_right (sample_right)
	);

	sigma_delta_dac dac_l_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.din     (sample_left),
		.dout    (audio_l)
	);

	sigma_delta_dac dac_r_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.din     (sample_right),
		.dout    (audio_r)
	);

endmodule

`default_nettype wire

//--- testbench/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// row kinds
// RESET data[1:0] is the machine mode
// IO port write of data to addr
// RD and WR are memory accesses, expected is the external address
// SAMPLE and DAC expected holds right in 31..16 and left in 15..0
// CE data[2:0] is the frequency code, data[3] pause, expected the ce_cpu_p count
typedef enum int {
	OP_RESET,
	OP_IO,
	OP_RD,
	OP_WR,
	OP_SAMPLE,
	OP_CE,
	OP_DAC
} op_e;

typedef struct {
	string       name;
	op_e         op;
	logic [15:0] addr;
	logic [7:0]  data;
	logic        exp_we;
	logic [31:0] expected;
} vector_t;

localparam int NUM_VECTORS = 35;

vector_t vectors [NUM_VECTORS] = '{
	// 128 mode reads, rom bank 6 then pages 5, 2, 3
	'{"rd_rom_128",     OP_RD,     16'h0123, 8'h00, 1'b0, 32'h0021_8123},
	'{"rd_q1_128",      OP_RD,     16'h4567, 8'h00, 1'b0, 32'h0001_4567},
	'{"rd_q2_128",      OP_RD,     16'h8abc, 8'h00, 1'b0, 32'h0000_8abc},
	'{"page_3",         OP_IO,     16'h7ffd, 8'h03, 1'b0, 32'h0000_0000},
	'{"rd_q3_page3",    OP_RD,     16'hc010, 8'h00, 1'b0, 32'h0000_c010},
	// rom writes go out as reads
	'{"wr_rom_128",     OP_WR,     16'h0200, 8'h55, 1'b0, 32'h0021_8200},
	'{"wr_q3_page3",    OP_WR,     16'hc400, 8'ha5, 1'b1, 32'h0000_c400},
	'{"lock_page1",     OP_IO,     16'h7ffd, 8'h21, 1'b0, 32'h0000_0000},
	'{"rd_q3_page1",    OP_RD,     16'hc000, 8'h00, 1'b0, 32'h0000_4000},
	'{"locked_write",   OP_IO,     16'h7ffd, 8'h06, 1'b0, 32'h0000_0000},
	'{"rd_q3_locked",   OP_RD,     16'hc000, 8'h00, 1'b0, 32'h0000_4000},
	// audio, dac bytes at x32 and ear at x8192
	'{"covox",          OP_IO,     16'h00fb, 8'h40, 1'b0, 32'h0000_0000},
	'{"covox_samples",  OP_SAMPLE, 16'h0000, 8'h00, 1'b0, 32'h1000_1000},
	'{"sd_a",           OP_IO,     16'h000f, 8'h10, 1'b0, 32'h0000_0000},
	'{"sd_a_samples",   OP_SAMPLE, 16'h0000, 8'h00, 1'b0, 32'h1000_0a00},
	'{"ear_on",         OP_IO,     16'h00fe, 8'h10, 1'b0, 32'h0000_0000},
	'{"ear_samples",    OP_SAMPLE, 16'h0000, 8'h00, 1'b0, 32'h3000_2a00},
	'{"dac_density",    OP_DAC,    16'h0000, 8'h00, 1'b0, 32'h3000_2a00},
	// 256 cycles over periods of 32 down to 2
	'{"ce_freq0",       OP_CE,     16'h0000, 8'h00, 1'b0, 32'd8},
	'{"ce_freq1",       OP_CE,     16'h0000, 8'h01, 1'b0, 32'd16},
	'{"ce_freq2",       OP_CE,     16'h0000, 8'h02, 1'b0, 32'd32},
	'{"ce_freq3",       OP_CE,     16'h0000, 8'h03, 1'b0, 32'd64},
	'{"ce_freq4",       OP_CE,     16'h0000, 8'h04, 1'b0, 32'd128},
	'{"ce_pause",       OP_CE,     16'h0000, 8'h0c, 1'b0, 32'd0},
	// +3 machine, all-ram layouts and the upper rom banks
	'{"reset_plus3",    OP_RESET,  16'h0000, 8'h02, 1'b0, 32'h0000_0000},
	'{"special_03",     OP_IO,     16'h1ffd, 8'h03, 1'b0, 32'h0000_0000},
	'{"rd_q0_page4",    OP_RD,     16'h0010, 8'h00, 1'b0, 32'h0001_0010},
	'{"rd_q1_page5",    OP_RD,     16'h4020, 8'h00, 1'b0, 32'h0001_4020},
	'{"rd_q2_page6",    OP_RD,     16'h8030, 8'h00, 1'b0, 32'h0001_8030},
	'{"rd_q3_page7",    OP_RD,     16'hc040, 8'h00, 1'b0, 32'h0001_c040},
	'{"special_05",     OP_IO,     16'h1ffd, 8'h05, 1'b0, 32'h0000_0000},
	'{"rd_q3_page3_sp", OP_RD,     16'hc040, 8'h00, 1'b0, 32'h0000_c040},
	'{"rom_hi_7ffd",    OP_IO,     16'h7ffd, 8'h10, 1'b0, 32'h0000_0000},
	'{"normal_04",      OP_IO,     16'h1ffd, 8'h04, 1'b0, 32'h0000_0000},
	'{"rd_rom_bank11",  OP_RD,     16'h0100, 8'h00, 1'b0, 32'h0022_c100}
};

`endif

//--- testbench/tb_zx_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_zx_core import zx_pkg::*; ();
	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	localparam int WAIT_LIMIT = 64;
	localparam logic [31:0] SEED = 32'h6adf_f27e;

	logic                clk_sys;
	logic                reset;
	cpu_bus_t            bus;
	core_cfg_t           cfg;
	logic                mem_req_valid;
	mem_req_t            mem_req;
	logic                mem_req_ready;
	logic                ce_cpu_p;
	logic                ce_cpu_n;
	logic [SAMPLE_W-1:0] sample_left;
	logic [SAMPLE_W-1:0] sample_right;
	logic                audio_l;
	logic                audio_r;

	int   errors;
	int   checks;
	logic timed_out;

	`include "tb_vectors.svh"

	zx_core_top dut_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// memory side takes requests at random
	initial begin
		mem_req_ready = 1'b0;
		void'($urandom(SEED));
		forever begin
			@(negedge clk_sys);
			mem_req_ready = 1'($urandom);
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual, input int tol);
		int diff;
		diff = int'(actual) - int'(expected);
		checks++;
		if ($isunknown(actual) || diff > tol || diff < -tol) begin
			errors++;
			$display("MISMATCH %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
		end
	endtask

	task automatic report_timeout(input string what);
		errors++;
		timed_out = 1'b1;
		$display("timeout while waiting for %s", what);
	endtask

	task automatic wait_valid(input logic level, input string what);
		int cycles;
		cycles = 0;
		while (mem_req_valid !== level && !timed_out) begin
			if (cycles == WAIT_LIMIT)
				report_timeout(what);
			else
				@(negedge clk_sys);
			cycles++;
		end
	endtask

	task automatic wait_ce_p();
		int cycles;
		cycles = 0;
		while (ce_cpu_p !== 1'b1 && !timed_out) begin
			if (cycles == WAIT_LIMIT)
				report_timeout("a ce_cpu_p pulse after the speed change");
			else
				@(negedge clk_sys);
			cycles++;
		end
	endtask

	// mode is sampled by the core while reset is high
	task automatic apply_reset(input mem_mode_e mode);
		bus = '0;
		cfg.mem_mode = mode;
		cfg.cpu_freq = 3'd0;
		cfg.pause = 1'b0;
		reset = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	// one write cycle, then the 3 cycles a write needs to reach the samples
	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		bus.addr = addr;
		bus.data = data;
		bus.iorq = 1'b1;
		bus.wr = 1'b1;
		@(negedge clk_sys);
		bus.iorq = 1'b0;
		bus.wr = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic mem_access(input vector_t row);
		mem_req_t got;
		bus.addr = row.addr;
		bus.data = row.data;
		bus.mreq = 1'b1;
		bus.rd = row.op == OP_RD;
		bus.wr = row.op == OP_WR;
		wait_valid(1'b1, "a memory request");
		got = mem_req;
		wait_valid(1'b0, "the end of the memory handshake");
		bus.mreq = 1'b0;
		bus.rd = 1'b0;
		bus.wr = 1'b0;
		// strobes low across one edge before the next access
		@(negedge clk_sys);
		if (!timed_out) begin
			check_value(row.name, row.expected, 32'(got.addr), 0);
			check_value({row.name, " we"}, 32'(row.exp_we), 32'(got.we), 0);
			if (row.exp_we)
				check_value({row.name, " data"}, 32'(row.data), 32'(got.data), 0);
		end
	endtask

	task automatic count_ce_p(input vector_t row);
		int count;
		int count_n;
		int cycle;
		int last_p;
		int gap;
		cfg.cpu_freq = row.data[2:0];
		cfg.pause = row.data[3];
		// a speed change holds the cpu for up to five n points, 32 cycles apart at most
		repeat (256) @(negedge clk_sys);
		if (!cfg.pause)
			wait_ce_p();
		count = 0;
		count_n = 0;
		cycle = 0;
		last_p = -1;
		gap = -1;
		repeat (256) begin
			@(negedge clk_sys);
			cycle++;
			if (ce_cpu_p === 1'b1) begin
				count++;
				last_p = cycle;
			end
			if (ce_cpu_n === 1'b1) begin
				count_n++;
				// n pulse sits half a period after p
				if (gap < 0 && last_p >= 0)
					gap = cycle - last_p;
			end
		end
		if (!timed_out) begin
			check_value(row.name, row.expected, count, row.expected == 0 ? 0 : 1);
			check_value({row.name, " n"}, row.expected, count_n, row.expected == 0 ? 0 : 1);
			if (row.expected != 0)
				check_value({row.name, " n gap"}, 128 / row.expected, gap, 0);
		end
	endtask

	task automatic count_dac_ones(input vector_t row);
		int ones_l;
		int ones_r;
		ones_l = 0;
		ones_r = 0;
		repeat (65536) begin
			@(negedge clk_sys);
			ones_l += int'(audio_l);
			ones_r += int'(audio_r);
		end
		check_value({row.name, " left"}, row.expected[15:0], ones_l, 1);
		check_value({row.name, " right"}, row.expected[31:16], ones_r, 1);
	endtask

	task automatic run_vector(input vector_t row);
		case (row.op)
			OP_RESET: apply_reset(mem_mode_e'(row.data[1:0]));
			OP_IO:    io_write(row.addr, row.data);
			OP_RD,
			OP_WR:    mem_access(row);
			OP_SAMPLE: begin
				check_value({row.name, " left"}, row.expected[15:0], sample_left, 0);
				check_value({row.name, " right"}, row.expected[31:16], sample_right, 0);
			end
			OP_CE:    count_ce_p(row);
			default:  count_dac_ones(row);
		endcase
	endtask

	initial begin
		errors = 0;
		checks = 0;
		timed_out = 1'b0;
		reset = 1'b1;
		bus = '0;
		cfg = '0;
		apply_reset(MODE_128);
		foreach (vectors[i]) begin
			if (!timed_out)
				run_vector(vectors[i]);
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
hw/zx_pkg.sv
hw/sigma_delta_dac.sv
hw/audio_mixer.sv
hw/page_mapper.sv
hw/cpu_clk_gen.sv
hw/bus_ctrl.sv
hw/zx_core_top.sv
+incdir+testbench
testbench/tb_zx_core.sv

//--- Bender.yml
package:
  name: zx_core

sources:
  - hw/zx_pkg.sv
  - hw/sigma_delta_dac.sv
  - hw/audio_mixer.sv
  - hw/page_mapper.sv
  - hw/cpu_clk_gen.sv
  - hw/bus_ctrl.sv
  - hw/zx_core_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_zx_core.sv
